// File: rtl/fir_adder_tree.sv
/*
 * FIR adder tree
 * sums the 25 products over five registered levels, then scales,
 * saturates to sample width and registers the result
 */
`timescale 1ns/100ps

module fir_adder_tree (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_clk_ena,
	input  fir_types_pkg::prod_beat_t  i_prods,
	output fir_types_pkg::out_beat_t   o_out
);

	localparam int N_FOLD = fir_coeff_pkg::N_FOLD;
	localparam int LEVELS = fir_coeff_pkg::TREE_LEVELS;

	// clamp limits of a signed sample
	localparam fir_types_pkg::acc_t SAT_MAX = (1 <<< (fir_types_pkg::SAMPLE_W - 1)) - 1;
	localparam fir_types_pkg::acc_t SAT_MIN = -(1 <<< (fir_types_pkg::SAMPLE_W - 1));

	// partial sums left after a number of levels, 25 13 7 4 2 1
	function automatic int level_len(input int lvl);
		int n;
		n = N_FOLD;
		for (int i = 0; i < lvl; i++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	// row 0 is the product vector, row l the registers of level l
	fir_types_pkg::acc_t node [LEVELS+1][N_FOLD];
	logic [LEVELS:0]     node_vld;

	fir_types_pkg::acc_t    scaled;
	fir_types_pkg::sample_t sat;

	for (genvar k = 0; k < N_FOLD; k++) begin : g_ext
		assign node[0][k] = fir_types_pkg::acc_t'($signed(i_prods.prod[k]));
	end
	assign node_vld[0] = i_prods.valid;

	// ******************************
	// summing levels
	// ******************************
	for (genvar l = 1; l <= LEVELS; l++) begin : g_lvl
		localparam int N_IN = level_len(l - 1);
		localparam int N_OUT = level_len(l);

		fir_types_pkg::acc_t sum_d [N_OUT];
		fir_types_pkg::acc_t sum_q [N_OUT];
		logic                vld_q;

		for (genvar k = 0; k < N_OUT; k++) begin : g_node
			if (2 * k + 1 < N_IN) begin : g_pair
				assign sum_d[k] = node[l-1][2*k] + node[l-1][2*k+1];
			end else begin : g_bye
				// odd leftover rides through to the next level
				assign sum_d[k] = node[l-1][2*k];
			end
		end

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				vld_q <= 1'b0;
			end else if (i_clk_ena) begin
				vld_q <= node_vld[l-1];
			end
		end

		always_ff @(posedge clk) begin
			if (i_clk_ena) begin
				sum_q <= sum_d;
			end
		end

		for (genvar k = 0; k < N_FOLD; k++) begin : g_row
			if (k < N_OUT) begin : g_used
				assign node[l][k] = sum_q[k];
			end else begin : g_pad
				assign node[l][k] = '0;
			end
		end
		assign node_vld[l] = vld_q;
	end

	// ******************************
	// scale and saturate
	// ******************************
	// arithmetic shift floors toward minus infinity
	assign scaled = node[LEVELS][0] >>> fir_coeff_pkg::SCALE_SHIFT;

	always_comb begin
		if (scaled > SAT_MAX) begin
			sat = fir_types_pkg::sample_t'(SAT_MAX);
		end else if (scaled < SAT_MIN) begin
			sat = fir_types_pkg::sample_t'(SAT_MIN);
		end else begin
			sat = fir_types_pkg::sample_t'(scaled);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_out <= '0;
		end else if (i_clk_ena) begin
			o_out <= '{valid: node_vld[LEVELS], sample: sat};
		end
	end

endmodule

// File: rtl/fir_coeff_pkg.sv
/*
 * FIR coefficient set
 * tap count, fold count, tree depth, output scaling and the
 * unique coefficients of the symmetric 49-tap response
 */
package fir_coeff_pkg;

	// ******************************
	// filter shape
	// ******************************
	localparam int N_TAPS = 49;
	// unique coefficients, center tap included
	localparam int N_FOLD = (N_TAPS + 1) / 2;
	// pairwise summing levels down to one value
	localparam int TREE_LEVELS = $clog2(N_FOLD);
	// output normalization, arithmetic right shift
	localparam int SCALE_SHIFT = 17;
	localparam int COEFF_W = 18;

	// ******************************
	// coefficient table
	// ******************************
	// index 0 pairs with tap 0 and tap 48, index 24 is the center tap
	// entries read back unsigned, cast to coeff_t before use
	localparam logic signed [N_FOLD-1:0][COEFF_W-1:0] COEFFS = {
		18'sd2360,   18'sd2278,   18'sd2147,   18'sd1971,   18'sd1756,
		18'sd1514,   18'sd1252,   18'sd980,    18'sd710,    18'sd451,
		18'sd212,    18'sd0,      -18'sd178,   -18'sd319,   -18'sd420,
		-18'sd481,   -18'sd504,   -18'sd490,   -18'sd447,   -18'sd380,
		-18'sd294,   -18'sd197,   -18'sd97,    18'sd0,      18'sd88
	};

endpackage

// File: rtl/fir_filter_top.sv
/*
 * FIR filter top
 * symmetric 49-tap filter, delay line into fold/multiply into adder tree
 */
`timescale 1ns/100ps

module fir_filter_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_clk_ena,
	input  logic                    i_valid,
	input  fir_types_pkg::sample_t  i_sample,
	output logic                    o_valid,
	output fir_types_pkg::sample_t  o_sample
);

	fir_types_pkg::tap_beat_t  taps;
	fir_types_pkg::prod_beat_t prods;
	fir_types_pkg::out_beat_t  out_beat;

	// 1 edge
	fir_tap_line u_tap_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_taps    (taps)
	);

	// 2 edges
	fir_fold_mult u_fold_mult (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_taps    (taps),
		.o_prods   (prods)
	);

	// 6 edges, output register included
	fir_adder_tree u_adder_tree (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_prods   (prods),
		.o_out     (out_beat)
	);

	assign o_valid = out_beat.valid;
	assign o_sample = out_beat.sample;

endmodule

// File: rtl/fir_fold_mult.sv
/*
 * FIR fold and multiply
 * pre-adds symmetric tap pairs, then multiplies each sum by its coefficient,
 * one register stage each, at full precision
 */
`timescale 1ns/100ps

module fir_fold_mult (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_clk_ena,
	input  fir_types_pkg::tap_beat_t   i_taps,
	output fir_types_pkg::prod_beat_t  o_prods
);

	localparam int N_TAPS = fir_coeff_pkg::N_TAPS;
	localparam int N_FOLD = fir_coeff_pkg::N_FOLD;

	fir_types_pkg::presum_t [N_FOLD-1:0] presum_d;
	fir_types_pkg::presum_t [N_FOLD-1:0] presum_q;
	logic                                fold_vld_q;
	fir_types_pkg::fold_beat_t           fold;

	fir_types_pkg::prod_t [N_FOLD-1:0]   prod_d;
	fir_types_pkg::prod_t [N_FOLD-1:0]   prod_q;
	logic                                prod_vld_q;

	// ******************************
	// stage 1, symmetric pre-add
	// ******************************
	always_comb begin
		for (int k = 0; k < N_FOLD - 1; k++) begin
			presum_d[k] = fir_types_pkg::presum_t'($signed(i_taps.taps[k]))
				+ fir_types_pkg::presum_t'($signed(i_taps.taps[N_TAPS-1-k]));
		end
		// center tap has no partner
		presum_d[N_FOLD-1] = fir_types_pkg::presum_t'($signed(i_taps.taps[N_FOLD-1]));
	end

	assign fold = '{valid: fold_vld_q, presum: presum_q};

	// ******************************
	// stage 2, coefficient multiply
	// ******************************
	// 19 x 18 signed gives the full 37-bit product
	always_comb begin
		for (int k = 0; k < N_FOLD; k++) begin
			prod_d[k] = $signed(fold.presum[k])
				* fir_types_pkg::coeff_t'(fir_coeff_pkg::COEFFS[k]);
		end
	end

	// valid flags follow the data registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fold_vld_q <= 1'b0;
			prod_vld_q <= 1'b0;
		end else if (i_clk_ena) begin
			fold_vld_q <= i_taps.valid;
			prod_vld_q <= fold.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			presum_q <= presum_d;
			prod_q <= prod_d;
		end
	end

	assign o_prods = '{valid: prod_vld_q, prod: prod_q};

endmodule

// File: rtl/fir_tap_line.sv
/*
 * FIR tap delay line
 * 49-deep sample shift register, valid flag registered beside the window
 */
`timescale 1ns/100ps

module fir_tap_line (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_clk_ena,
	input  logic                      i_valid,
	input  fir_types_pkg::sample_t    i_sample,
	output fir_types_pkg::tap_beat_t  o_taps
);

	localparam int N_TAPS = fir_coeff_pkg::N_TAPS;

	// ******************************
	// window register
	// ******************************
	// invalid samples still shift in, the flag tells them apart
	// history is cleared so a reset starts the filter from silence
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_taps <= '0;
		end else if (i_clk_ena) begin
			o_taps.valid <= i_valid;
			// oldest sample drops off the top
			o_taps.taps <= {o_taps.taps[N_TAPS-2:0], i_sample};
		end
	end

endmodule

// File: rtl/fir_types_pkg.sv
/*
 * FIR datapath types
 * sample and arithmetic widths plus the beat structs passed between stages
 */
package fir_types_pkg;

	// ******************************
	// widths
	// ******************************
	localparam int SAMPLE_W = 18;
	// sum of two taps needs one extra bit
	localparam int PRESUM_W = SAMPLE_W + 1;
	localparam int PROD_W = PRESUM_W + fir_coeff_pkg::COEFF_W;
	// one growth bit per tree level, plus a spare
	localparam int ACC_W = PROD_W + fir_coeff_pkg::TREE_LEVELS + 1;

	// ******************************
	// numeric types
	// ******************************
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [PRESUM_W-1:0] presum_t;
	typedef logic signed [fir_coeff_pkg::COEFF_W-1:0] coeff_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// ******************************
	// stage beats
	// ******************************
	// tap 0 holds the newest sample
	typedef struct packed {
		logic valid;
		sample_t [fir_coeff_pkg::N_TAPS-1:0] taps;
	} tap_beat_t;

	typedef struct packed {
		logic valid;
		presum_t [fir_coeff_pkg::N_FOLD-1:0] presum;
	} fold_beat_t;

	typedef struct packed {
		logic valid;
		prod_t [fir_coeff_pkg::N_FOLD-1:0] prod;
	} prod_beat_t;

	typedef struct packed {
		logic valid;
		sample_t sample;
	} out_beat_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build the FIR testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/fir_tb_sim

verilator --binary -Wno-fatal --top-module fir_tb -f vlog.f \
	-Mdir obj_dir -o fir_tb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status, see $BUILD_LOG"
	exit 1
fi

"$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status, see $SIM_LOG"
	exit 1
fi

if grep -q "Done: no errors" "$SIM_LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see $SIM_LOG"
exit 1

// File: verification/fir_tb_table.svh
/*
 * FIR testbench step table
 * one row per test, applied in order by the stimulus loop
 */

// stimulus modes
localparam logic [1:0] MODE_IMPULSE = 2'd0;
localparam logic [1:0] MODE_CONST = 2'd1;
localparam logic [1:0] MODE_RANDOM = 2'd2;
localparam logic [1:0] MODE_RESET = 2'd3;

localparam int N_STEPS = 8;

typedef struct packed {
	logic [1:0]             mode;
	logic [15:0]            length;
	// bit i%8 per cycle, 8'h00 gives random stall periods
	logic [7:0]             ena_pat;
	logic [7:0]             val_pat;
	fir_types_pkg::sample_t level;
} step_t;

// columns: mode, cycles, enable pattern, valid pattern, sample level
localparam step_t STEPS [N_STEPS] = '{
	'{MODE_IMPULSE, 16'd64,  8'hff, 8'hff, 18'h1ffff},
	'{MODE_CONST,   16'd80,  8'hff, 8'hff, 18'h1ffff},
	// most negative sample
	'{MODE_CONST,   16'd80,  8'hff, 8'hff, 18'h20000},
	'{MODE_RANDOM,  16'd300, 8'hff, 8'hff, 18'h0},
	'{MODE_RANDOM,  16'd200, 8'h00, 8'hff, 18'h0},
	'{MODE_RANDOM,  16'd160, 8'hff, 8'hb5, 18'h0},
	'{MODE_RANDOM,  16'd96,  8'hdb, 8'h6e, 18'h0},
	'{MODE_RESET,   16'd120, 8'hff, 8'hff, 18'h0}
};

// File: verification/fir_tb.sv
/*
 * FIR filter testbench
 * runs the step table through the filter top and checks every
 * enabled output against a behavioral model of the symmetric FIR
 */
`timescale 1ns/100ps

module fir_tb;

	localparam int N_TAPS = fir_coeff_pkg::N_TAPS;
	// taps past the center reuse the mirrored coefficient
	localparam int HALF = (N_TAPS + 1) / 2;
	localparam int LATENCY = 9;
	localparam int DRAIN_TIMEOUT = 40;
	localparam longint OUT_MAX = 131071;
	localparam longint OUT_MIN = -131072;

	`include "fir_tb_table.svh"

	logic                   clk;
	logic                   reset;
	logic                   i_clk_ena;
	logic                   i_valid;
	fir_types_pkg::sample_t i_sample;
	logic                   o_valid;
	fir_types_pkg::sample_t o_sample;

	// model state with hist[0] as the newest sample
	fir_types_pkg::sample_t   hist [N_TAPS];
	fir_types_pkg::out_beat_t exp_q [$];
	// valid inputs not yet seen on o_valid
	int                       pending_valid;
	logic                     last_valid;
	fir_types_pkg::sample_t   last_sample;

	// inputs as the DUT saw them on the latest rising edge
	logic                   cap_reset;
	logic                   cap_ena;
	logic                   cap_valid;
	fir_types_pkg::sample_t cap_sample;

	logic [31:0] lcg_state;
	int          total_checks;
	int          total_errors;
	int          tests_run;

	fir_filter_top DUT (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_valid   (o_valid),
		.o_sample  (o_sample)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ******************************
	// helpers
	// ******************************
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic string step_name(input logic [1:0] mode);
		string name;
		case (mode)
			MODE_IMPULSE: name = "impulse";
			MODE_CONST:   name = "constant";
			MODE_RANDOM:  name = "random";
			default:      name = "reset pulse";
		endcase
		return name;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		total_checks++;
		if (got !== exp) begin
			total_errors++;
			$display("error: %s got %0h expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	// ******************************
	// reference model
	// ******************************
	// sum of h[k] * x[n-k] shifted down with floor and clamped to the sample range
	function automatic fir_types_pkg::sample_t model_output();
		longint                 acc;
		int                     idx;
		fir_types_pkg::coeff_t  c;
		acc = 0;
		for (int k = 0; k < N_TAPS; k++) begin
			idx = (k < HALF) ? k : N_TAPS - 1 - k;
			c = fir_coeff_pkg::COEFFS[idx];
			acc += longint'(c) * longint'(hist[k]);
		end
		acc = acc >>> fir_coeff_pkg::SCALE_SHIFT;
		if (acc > OUT_MAX) begin
			acc = OUT_MAX;
		end else if (acc < OUT_MIN) begin
			acc = OUT_MIN;
		end
		return fir_types_pkg::sample_t'(acc);
	endfunction

	task automatic model_clear();
		fir_types_pkg::out_beat_t idle;
		idle = '0;
		for (int k = 0; k < N_TAPS; k++) begin
			hist[k] = '0;
		end
		exp_q.delete();
		// stages between capture and output start out empty
		for (int k = 0; k < LATENCY - 1; k++) begin
			exp_q.push_back(idle);
		end
		pending_valid = 0;
	endtask

	task automatic model_edge();
		fir_types_pkg::out_beat_t beat;
		fir_types_pkg::out_beat_t head;
		if (reset || cap_reset) begin
			model_clear();
			check_value("o_valid", o_valid, 32'd0);
			check_value("o_sample", o_sample, 32'd0);
		end else if (cap_ena) begin
			for (int k = N_TAPS - 1; k > 0; k--) begin
				hist[k] = hist[k-1];
			end
			hist[0] = cap_sample;
			beat.valid = cap_valid;
			beat.sample = model_output();
			exp_q.push_back(beat);
			if (beat.valid) begin
				pending_valid++;
			end
			head = exp_q.pop_front();
			// each valid output of the DUT retires one pending sample
			if (o_valid) begin
				pending_valid--;
			end
			check_value("o_valid", o_valid, head.valid);
			if (head.valid) begin
				check_value("o_sample", o_sample, head.sample);
			end
		end else begin
			// outputs hold on a stalled edge
			check_value("o_valid", o_valid, last_valid);
			check_value("o_sample", o_sample, last_sample);
		end
		last_valid = o_valid;
		last_sample = o_sample;
	endtask

	// inputs read at the rising edge and outputs half a cycle later
	initial begin : monitor
		pending_valid = 0;
		last_valid = 1'b0;
		last_sample = '0;
		forever begin
			@(posedge clk);
			cap_reset = reset;
			cap_ena = i_clk_ena;
			cap_valid = i_valid;
			cap_sample = i_sample;
			@(negedge clk);
			model_edge();
		end
	end

	// ******************************
	// stimulus
	// ******************************
	task automatic run_step(input step_t s);
		int                     stall_left;
		int                     mid;
		logic [31:0]            r;
		logic                   ena;
		logic                   vld;
		fir_types_pkg::sample_t smp;
		stall_left = 0;
		mid = int'(s.length) / 2;
		for (int i = 0; i < int'(s.length); i++) begin
			if (s.ena_pat != 8'h00) begin
				ena = s.ena_pat[i % 8];
			end else if (stall_left > 0) begin
				ena = 1'b0;
				stall_left--;
			end else begin
				r = lcg_next();
				ena = (r[30:28] != 3'd0);
				if (!ena) begin
					stall_left = int'(r[27:26]) + 1;
				end
			end
			vld = s.val_pat[i % 8];
			case (s.mode)
				MODE_IMPULSE: smp = (i == 0) ? s.level : '0;
				MODE_CONST:   smp = s.level;
				default: begin
					r = lcg_next();
					smp = r[30:13];
				end
			endcase
			@(posedge clk);
			if (s.mode == MODE_RESET) begin
				reset <= (i >= mid) && (i < mid + 3);
			end
			i_clk_ena <= ena;
			i_valid <= vld;
			i_sample <= vld ? smp : '0;
		end
	endtask

	// idle input until every valid sample has left the pipeline
	task automatic drain_pipeline(output bit ok);
		int guard;
		guard = 0;
		@(posedge clk);
		i_clk_ena <= 1'b1;
		i_valid <= 1'b0;
		i_sample <= '0;
		while (pending_valid > 0 && guard < DRAIN_TIMEOUT) begin
			@(posedge clk);
			guard++;
		end
		ok = (pending_valid <= 0);
		if (!ok) begin
			total_errors++;
			$display("timeout: %0d valid samples still in the pipeline after %0d cycles",
				pending_valid, guard);
		end
	endtask

	initial begin : stimulus
		int start_checks;
		int start_errors;
		bit drained;
		lcg_state = 32'd32;
		total_checks = 0;
		total_errors = 0;
		tests_run = 0;
		drained = 1'b1;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_sample = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int s = 0; s < N_STEPS; s++) begin
			start_checks = total_checks;
			start_errors = total_errors;
			run_step(STEPS[s]);
			drain_pipeline(drained);
			tests_run++;
			$display("test %0d %s, %0d cycles, ena %h, valid %h: %0d checks, %0d errors",
				s, step_name(STEPS[s].mode), STEPS[s].length, STEPS[s].ena_pat,
				STEPS[s].val_pat, total_checks - start_checks,
				total_errors - start_errors);
			if (!drained) begin
				break;
			end
		end
		$display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+verification
rtl/fir_coeff_pkg.sv
rtl/fir_types_pkg.sv
rtl/fir_tap_line.sv
rtl/fir_fold_mult.sv
rtl/fir_adder_tree.sv
rtl/fir_filter_top.sv
verification/fir_tb.sv
